/* design/mlp_consts.svh */
`ifndef MLP_CONSTS_SVH
`define MLP_CONSTS_SVH

// node counts per layer
`define MLP_N_IN        2
`define MLP_N_H1        4
`define MLP_N_H2        4
`define MLP_N_OUT       3

// signed Q8.8
`define MLP_FRAC_BITS   8
`define MLP_WORD_W      16

// headroom for up to a few hundred products
`define MLP_ACC_W       40

// negative slope of 1/8
`define MLP_LEAKY_SHIFT 3

// node index, up to 8 nodes per layer
`define MLP_NODE_W      3

// weight address inside one layer
`define MLP_WADDR_W     5

// activation RAM is layer*8 + node, weight RAM is layer*32 + local address
`define MLP_ACT_DEPTH   32
`define MLP_W_DEPTH     128

`endif

/* design/mlp_pkg.sv */
`default_nettype none

`include "mlp_consts.svh"

package mlp_pkg;

	typedef logic signed [`MLP_WORD_W-1:0] word_t;   // Q8.8
	typedef logic signed [`MLP_ACC_W-1:0]  acc_t;
	typedef logic [1:0]                    layer_t;
	typedef logic [`MLP_NODE_W-1:0]        node_t;
	typedef logic [`MLP_WADDR_W-1:0]       waddr_t;

	typedef enum logic [1:0] {
		mode_load_weights,
		mode_load_state,
		mode_compute,
		mode_finish
	} mode_t;

	// layer codes
	localparam layer_t layer_in  = 2'd0;
	localparam layer_t layer_h1  = 2'd1;
	localparam layer_t layer_h2  = 2'd2;
	localparam layer_t layer_out = 2'd3;

endpackage

`default_nettype wire

/* design/sync_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_ram
	import mlp_pkg::*;
#(
	parameter int DEPTH = 32
) (
	input  logic                     clk,
	input  logic                     i_en,
	input  logic                     i_we,
	input  logic [$clog2(DEPTH)-1:0] i_addr,
	input  word_t                    i_wdata,
	output word_t                    o_rdata
);

	word_t mem [DEPTH];

	// read data only updates on enabled reads
	always_ff @(posedge clk) begin
		if (i_en) begin
			if (i_we) begin
				mem[i_addr] <= i_wdata;
			end else begin
				o_rdata <= mem[i_addr];
			end
		end
	end

endmodule

`default_nettype wire

/* design/neuron_mac.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mlp_consts.svh"

module neuron_mac
	import mlp_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_start,
	input  logic  i_valid,
	input  logic  i_bias,
	input  logic  i_last,
	input  logic  i_leaky,
	input  word_t i_weight,
	input  word_t i_act,
	output logic  o_result_valid,
	output word_t o_result
);

	localparam word_t one_q    = word_t'(1 << `MLP_FRAC_BITS);       // 1.0
	localparam acc_t  word_max = acc_t'((1 << (`MLP_WORD_W - 1)) - 1);
	localparam acc_t  word_min = -acc_t'(1 << (`MLP_WORD_W - 1));

	word_t                            act_op;
	logic signed [2*`MLP_WORD_W-1:0] prod;
	acc_t                             term;
	acc_t                             sum;
	acc_t                             scaled;
	acc_t                             acc;
	word_t                            sat;
	word_t                            act_out;

	always_comb begin
		act_op = i_bias ? one_q : i_act;
		prod   = i_weight * act_op;
		term   = acc_t'(prod);                      // sign extend
		sum    = i_start ? term : acc + term;
		scaled = sum >>> `MLP_FRAC_BITS;            // floor
		if (scaled > word_max) begin
			sat = word_t'(word_max);
		end else if (scaled < word_min) begin
			sat = word_t'(word_min);
		end else begin
			sat = word_t'(scaled);
		end
		act_out = (i_leaky && sat < 0) ? (sat >>> `MLP_LEAKY_SHIFT) : sat;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= i_valid && i_last;
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			acc <= sum;
		end
		if (i_valid && i_last) begin
			o_result <= act_out;
		end
	end

endmodule

`default_nettype wire

/* design/argmax_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module argmax_unit
	import mlp_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  i_valid,
	input  node_t i_addr,
	input  word_t i_data,
	input  logic  i_last,
	output logic  o_valid,
	output node_t o_arg_max
);

	logic  have_max;   // a maximum is held for the current vector
	word_t best_val;
	node_t best_idx;
	logic  take_new;
	word_t cand_val;
	node_t cand_idx;

	// strictly greater, so ties keep the lower index
	assign take_new = !have_max || (i_data > best_val);
	assign cand_val = take_new ? i_data : best_val;
	assign cand_idx = take_new ? i_addr : best_idx;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_valid  <= 1'b0;
			have_max <= 1'b0;
		end else begin
			o_valid <= i_valid && i_last;
			if (i_valid) begin
				have_max <= !i_last;   // restart after the last element
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			best_val <= cand_val;
			best_idx <= cand_idx;
		end
		if (i_valid && i_last) begin
			o_arg_max <= cand_idx;
		end
	end

endmodule

`default_nettype wire

/* design/net_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mlp_consts.svh"

module net_controller
	import mlp_pkg::*;
(
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           i_weight_valid,
	input  layer_t                         i_weight_layer,
	input  waddr_t                         i_weight_addr,
	input  word_t                          i_weight,
	input  logic                           i_data_valid,
	input  node_t                          i_data_addr,
	input  word_t                          i_data,
	input  logic                           i_result_valid,
	input  word_t                          i_result,
	output logic                           o_w_en,
	output logic                           o_w_we,
	output logic [$clog2(`MLP_W_DEPTH)-1:0] o_w_addr,
	output word_t                          o_w_wdata,
	output logic                           o_a_en,
	output logic                           o_a_we,
	output logic [$clog2(`MLP_ACT_DEPTH)-1:0] o_a_addr,
	output word_t                          o_a_wdata,
	output logic                           o_acc_start,
	output logic                           o_acc_valid,
	output logic                           o_acc_bias,
	output logic                           o_acc_last,
	output logic                           o_acc_leaky,
	output logic                           o_valid,
	output node_t                          o_addr,
	output word_t                          o_data,
	output logic                           o_out_last
);

	localparam waddr_t last_w  = waddr_t'(`MLP_N_OUT * (`MLP_N_H2 + 1) - 1);
	localparam node_t  last_in = node_t'(`MLP_N_IN - 1);

	mode_t  mode;
	layer_t layer;
	node_t  node;
	node_t  term;
	logic   reading;    // issuing reads, else waiting for the MAC
	logic   rd_start;
	logic   rd_bias;
	node_t  prev_n;
	node_t  layer_n;
	waddr_t w_local;
	logic   is_bias;
	logic   node_done;

	always_comb begin
		case (layer)
			layer_h1: begin
				prev_n  = node_t'(`MLP_N_IN);
				layer_n = node_t'(`MLP_N_H1);
			end
			layer_h2: begin
				prev_n  = node_t'(`MLP_N_H1);
				layer_n = node_t'(`MLP_N_H2);
			end
			default: begin
				prev_n  = node_t'(`MLP_N_H2);
				layer_n = node_t'(`MLP_N_OUT);
			end
		endcase
	end

	// node * (prev + 1) + term, bias at term == prev
	assign w_local   = waddr_t'(node) * (waddr_t'(prev_n) + waddr_t'(1)) + waddr_t'(term);
	assign is_bias   = (term == prev_n);
	assign node_done = (node == layer_n - node_t'(1));

	assign o_acc_leaky = (mode == mode_compute) && (layer != layer_out);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode        <= mode_load_weights;
			layer       <= layer_h1;
			node        <= '0;
			term        <= '0;
			reading     <= 1'b0;
			rd_start    <= 1'b0;
			rd_bias     <= 1'b0;
			o_w_en      <= 1'b0;
			o_w_we      <= 1'b0;
			o_a_en      <= 1'b0;
			o_a_we      <= 1'b0;
			o_acc_start <= 1'b0;
			o_acc_valid <= 1'b0;
			o_acc_bias  <= 1'b0;
			o_acc_last  <= 1'b0;
			o_valid     <= 1'b0;
			o_out_last  <= 1'b0;
		end else begin
			o_w_en     <= 1'b0;
			o_w_we     <= 1'b0;
			o_a_en     <= 1'b0;
			o_a_we     <= 1'b0;
			rd_start   <= 1'b0;
			rd_bias    <= 1'b0;
			o_valid    <= 1'b0;
			o_out_last <= 1'b0;

			// MAC strobes line up with RAM read data
			o_acc_valid <= o_w_en && !o_w_we;
			o_acc_start <= rd_start;
			o_acc_bias  <= rd_bias;
			o_acc_last  <= rd_bias;   // bias is always the last term

			case (mode)
				mode_load_weights: begin
					if (i_weight_valid) begin
						o_w_en <= 1'b1;
						o_w_we <= 1'b1;
						if (i_weight_layer == layer_out && i_weight_addr == last_w) begin
							mode <= mode_load_state;
						end
					end
				end
				mode_load_state: begin
					if (i_data_valid) begin
						o_a_en <= 1'b1;
						o_a_we <= 1'b1;
						if (i_data_addr == last_in) begin
							mode    <= mode_compute;
							layer   <= layer_h1;
							node    <= '0;
							term    <= '0;
							reading <= 1'b1;
						end
					end
				end
				mode_compute: begin
					if (reading) begin
						o_w_en   <= 1'b1;
						o_a_en   <= !is_bias;     // bias uses 1.0, no activation read
						rd_start <= (term == '0);
						rd_bias  <= is_bias;
						if (is_bias) begin
							reading <= 1'b0;
						end else begin
							term <= term + node_t'(1);
						end
					end else if (i_result_valid) begin
						o_a_en  <= 1'b1;        // write back
						o_a_we  <= 1'b1;
						term    <= '0;
						reading <= 1'b1;
						if (layer == layer_out) begin
							o_valid    <= 1'b1;
							o_out_last <= node_done;
						end
						if (!node_done) begin
							node <= node + node_t'(1);
						end else if (layer == layer_out) begin
							node    <= '0;
							reading <= 1'b0;
							mode    <= mode_finish;
						end else begin
							node  <= '0;
							layer <= layer + layer_t'(1);
						end
					end
				end
				default: begin
					mode <= mode_load_state;   // weights stay loaded
				end
			endcase
		end
	end

	// addresses and data, qualified by the enables above
	always_ff @(posedge clk) begin
		case (mode)
			mode_load_weights: begin
				o_w_addr  <= {i_weight_layer, i_weight_addr};
				o_w_wdata <= i_weight;
			end
			mode_load_state: begin
				o_a_addr  <= {layer_in, i_data_addr};
				o_a_wdata <= i_data;
			end
			mode_compute: begin
				if (reading) begin
					o_w_addr <= {layer, w_local};
					o_a_addr <= {layer - layer_t'(1), term};
				end else begin
					o_a_addr  <= {layer, node};
					o_a_wdata <= i_result;
					o_addr    <= node;
					o_data    <= i_result;
				end
			end
			default: begin
				o_addr <= node;
			end
		endcase
	end

endmodule

`default_nettype wire

/* design/mlp_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mlp_consts.svh"

module mlp_top
	import mlp_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_weight_valid,
	input  layer_t i_weight_layer,
	input  waddr_t i_weight_addr,
	input  word_t  i_weight,
	input  logic   i_data_valid,
	input  node_t  i_data_addr,
	input  word_t  i_data,
	output logic   o_valid,
	output node_t  o_addr,
	output word_t  o_data,
	output logic   o_arg_max_valid,
	output node_t  o_arg_max
);

	logic                              w_en;
	logic                              w_we;
	logic [$clog2(`MLP_W_DEPTH)-1:0]   w_addr;
	word_t                             w_wdata;
	word_t                             w_rdata;
	logic                              a_en;
	logic                              a_we;
	logic [$clog2(`MLP_ACT_DEPTH)-1:0] a_addr;
	word_t                             a_wdata;
	word_t                             a_rdata;
	logic                              acc_start;
	logic                              acc_valid;
	logic                              acc_bias;
	logic                              acc_last;
	logic                              acc_leaky;
	logic                              result_valid;
	word_t                             result;
	logic                              out_last;

	net_controller u_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_weight_valid (i_weight_valid),
		.i_weight_layer (i_weight_layer),
		.i_weight_addr  (i_weight_addr),
		.i_weight       (i_weight),
		.i_data_valid   (i_data_valid),
		.i_data_addr    (i_data_addr),
		.i_data         (i_data),
		.i_result_valid (result_valid),
		.i_result       (result),
		.o_w_en         (w_en),
		.o_w_we         (w_we),
		.o_w_addr       (w_addr),
		.o_w_wdata      (w_wdata),
		.o_a_en         (a_en),
		.o_a_we         (a_we),
		.o_a_addr       (a_addr),
		.o_a_wdata      (a_wdata),
		.o_acc_start    (acc_start),
		.o_acc_valid    (acc_valid),
		.o_acc_bias     (acc_bias),
		.o_acc_last     (acc_last),
		.o_acc_leaky    (acc_leaky),
		.o_valid        (o_valid),
		.o_addr         (o_addr),
		.o_data         (o_data),
		.o_out_last     (out_last)
	);

	sync_ram #(.DEPTH(`MLP_W_DEPTH)) u_weight_ram (
		.clk     (clk),
		.i_en    (w_en),
		.i_we    (w_we),
		.i_addr  (w_addr),
		.i_wdata (w_wdata),
		.o_rdata (w_rdata)
	);

	// inputs and all layer outputs
	sync_ram #(.DEPTH(`MLP_ACT_DEPTH)) u_act_ram (
		.clk     (clk),
		.i_en    (a_en),
		.i_we    (a_we),
		.i_addr  (a_addr),
		.i_wdata (a_wdata),
		.o_rdata (a_rdata)
	);

	neuron_mac u_mac (
		.clk            (clk),
		.rst_n          (rst_n),
		.i_start        (acc_start),
		.i_valid        (acc_valid),
		.i_bias         (acc_bias),
		.i_last         (acc_last),
		.i_leaky        (acc_leaky),
		.i_weight       (w_rdata),
		.i_act          (a_rdata),
		.o_result_valid (result_valid),
		.o_result       (result)
	);

	argmax_unit u_argmax (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_valid   (o_valid),
		.i_addr    (o_addr),
		.i_data    (o_data),
		.i_last    (out_last),
		.o_valid   (o_arg_max_valid),
		.o_arg_max (o_arg_max)
	);

endmodule

`default_nettype wire

/* sim/tb_mlp_model.svh */
`ifndef TB_MLP_MODEL_SVH
`define TB_MLP_MODEL_SVH

`include "mlp_consts.svh"

// raw Q8.8 words, weights indexed [layer][local address]
typedef logic [3:0][(1 << `MLP_WADDR_W)-1:0][`MLP_WORD_W-1:0] wtab_t;
typedef logic [(1 << `MLP_NODE_W)-1:0][`MLP_WORD_W-1:0]       vec_t;

function automatic int layer_size(input int layer);
	case (layer)
		0: return `MLP_N_IN;
		1: return `MLP_N_H1;
		2: return `MLP_N_H2;
		default: return `MLP_N_OUT;
	endcase
endfunction

// back to Q8.8 by floor, clamp to the word range, then slope 1/8 below zero
function automatic int q_finish(input longint sum, input bit leaky);
	longint hi = (longint'(1) << (`MLP_WORD_W - 1)) - 1;
	longint lo = -(longint'(1) << (`MLP_WORD_W - 1));
	longint s;
	s = sum >>> `MLP_FRAC_BITS;
	if (s > hi) begin
		s = hi;
	end else if (s < lo) begin
		s = lo;
	end
	if (leaky && s < 0) begin
		s = s >>> `MLP_LEAKY_SHIFT;
	end
	return int'(s);
endfunction

function automatic int neuron_value(input wtab_t w, input int layer, input int node,
                                   input vec_t prev);
	int     n_prev;
	int     base;
	int     i;
	longint sum;
	n_prev = layer_size(layer - 1);
	base   = node * (n_prev + 1);
	sum    = longint'($signed(w[layer][base + n_prev])) <<< `MLP_FRAC_BITS;   // bias times 1.0
	for (i = 0; i < n_prev; i++) begin
		sum += longint'($signed(w[layer][base + i])) * longint'($signed(prev[i]));
	end
	return q_finish(sum, layer != 3);   // output layer has no activation
endfunction

function automatic vec_t forward_pass(input wtab_t w, input vec_t x);
	vec_t cur;
	vec_t nxt;
	int   l;
	int   n;
	int   v;
	cur = x;
	for (l = 1; l <= 3; l++) begin
		nxt = '0;
		for (n = 0; n < layer_size(l); n++) begin
			v      = neuron_value(w, l, n, cur);
			nxt[n] = v[`MLP_WORD_W-1:0];
		end
		cur = nxt;
	end
	return cur;
endfunction

function automatic int argmax_of(input vec_t y);
	int best;
	int i;
	best = 0;
	for (i = 1; i < `MLP_N_OUT; i++) begin
		if ($signed(y[i]) > $signed(y[best])) begin   // ties keep the lower index
			best = i;
		end
	end
	return best;
endfunction

`endif

/* sim/tb_mlp_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mlp_top
	import mlp_pkg::*;
();

	`include "tb_mlp_model.svh"

	localparam int timeout_cycles = 400;

	logic   clk;
	logic   rst_n;
	logic   i_weight_valid;
	layer_t i_weight_layer;
	waddr_t i_weight_addr;
	word_t  i_weight;
	logic   i_data_valid;
	node_t  i_data_addr;
	word_t  i_data;
	logic   o_valid;
	node_t  o_addr;
	word_t  o_data;
	logic   o_arg_max_valid;
	node_t  o_arg_max;

	integer seed;
	int     cycle;
	int     out_addr_q[$];
	int     out_data_q[$];
	int     out_cyc_q[$];
	int     arg_q[$];
	int     arg_cyc_q[$];
	wtab_t  w_cur;   // weights the DUT should hold

	mlp_top uut (
		.clk             (clk),
		.rst_n           (rst_n),
		.i_weight_valid  (i_weight_valid),
		.i_weight_layer  (i_weight_layer),
		.i_weight_addr   (i_weight_addr),
		.i_weight        (i_weight),
		.i_data_valid    (i_data_valid),
		.i_data_addr     (i_data_addr),
		.i_data          (i_data),
		.o_valid         (o_valid),
		.o_addr          (o_addr),
		.o_data          (o_data),
		.o_arg_max_valid (o_arg_max_valid),
		.o_arg_max       (o_arg_max)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic void check_value(input string test, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("FAILED %s: expected %0d, actual %0d", test, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endfunction

	// outputs sampled mid-cycle
	always @(negedge clk) begin
		cycle = cycle + 1;
		if (!rst_n) begin
			check_value("reset o_valid", 0, int'(o_valid));
			check_value("reset o_arg_max_valid", 0, int'(o_arg_max_valid));
		end
		if (o_valid) begin
			out_addr_q.push_back(int'(o_addr));
			out_data_q.push_back(int'(o_data));
			out_cyc_q.push_back(cycle);
		end
		if (o_arg_max_valid) begin
			arg_q.push_back(int'(o_arg_max));
			arg_cyc_q.push_back(cycle);
		end
	end

	function automatic word_t draw_word(input bit full);
		if (full) begin
			return word_t'($random(seed));
		end
		return word_t'($random(seed) % 513);   // within +-2.0
	endfunction

	function automatic wtab_t draw_weights(input bit directed);
		wtab_t w;
		int    l;
		int    a;
		int    row;
		w = '0;
		for (l = 1; l <= 3; l++) begin
			for (a = 0; a < layer_size(l) * (layer_size(l - 1) + 1); a++) begin
				w[l][a] = draw_word(directed && l == 1);   // full range saturates hidden 1
			end
		end
		if (directed) begin
			// rows 1 and 2 equal, row 0 pinned at -128.0
			row = `MLP_N_H2 + 1;
			for (a = 0; a < row; a++) begin
				w[3][a]           = '0;
				w[3][2 * row + a] = w[3][row + a];
			end
			w[3][row - 1] = 16'h8000;
		end
		return w;
	endfunction

	function automatic vec_t draw_state();
		vec_t x;
		int   i;
		x = '0;
		for (i = 0; i < `MLP_N_IN; i++) begin
			x[i] = draw_word(1'b0);
		end
		return x;
	endfunction

	task automatic clear_queues();
		out_addr_q.delete();
		out_data_q.delete();
		out_cyc_q.delete();
		arg_q.delete();
		arg_cyc_q.delete();
	endtask

	task automatic apply_reset();
		clear_queues();
		rst_n = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);
		check_value("post reset o_valid pulses", 0, out_data_q.size());
		check_value("post reset argmax pulses", 0, arg_q.size());
	endtask

	task automatic load_weights(input wtab_t w);
		int l;
		int a;
		for (l = 1; l <= 3; l++) begin
			for (a = 0; a < layer_size(l) * (layer_size(l - 1) + 1); a++) begin
				@(negedge clk);
				i_weight_valid = 1'b1;
				i_weight_layer = layer_t'(l);
				i_weight_addr  = waddr_t'(a);
				i_weight       = w[l][a];
			end
		end
		@(negedge clk);
		i_weight_valid = 1'b0;
	endtask

	// weights arriving outside load_weights must be ignored
	task automatic drive_stray_weights();
		int k;
		for (k = 0; k < 6; k++) begin
			@(negedge clk);
			i_weight_valid = 1'b1;
			i_weight_layer = layer_t'(1 + k % 3);
			i_weight_addr  = waddr_t'(k);
			i_weight       = word_t'($random(seed));
		end
		@(negedge clk);
		i_weight_valid = 1'b0;
	endtask

	task automatic load_state(input vec_t x, input bit stray);
		int i;
		for (i = 0; i < `MLP_N_IN; i++) begin
			@(negedge clk);
			i_data_valid = 1'b1;
			i_data_addr  = node_t'(i);
			i_data       = x[i];
		end
		for (i = 0; i < (stray ? 4 : 0); i++) begin
			@(negedge clk);   // compute is running now
			i_data_addr = node_t'(i % `MLP_N_IN);
			i_data      = word_t'($random(seed));
		end
		@(negedge clk);
		i_data_valid = 1'b0;
	endtask

	task automatic wait_for_argmax();
		int n;
		n = 0;
		while (arg_q.size() == 0) begin
			@(negedge clk);
			n++;
			if (n > timeout_cycles) begin
				$display("timeout: no argmax pulse after the state was loaded");
				$display("TESTS FAILED");
				$fatal(1);
			end
		end
	endtask

	task automatic run_pass(input string test, input vec_t x, input bit stray);
		vec_t expected;
		int   i;
		clear_queues();
		load_state(x, stray);
		wait_for_argmax();
		repeat (4) @(negedge clk);   // catch any extra pulses
		expected = forward_pass(w_cur, x);
		check_value($sformatf("%s output count", test), `MLP_N_OUT, out_data_q.size());
		for (i = 0; i < `MLP_N_OUT; i++) begin
			check_value($sformatf("%s addr[%0d]", test, i), i, out_addr_q[i]);
			check_value($sformatf("%s data[%0d]", test, i), int'($signed(expected[i])),
			            out_data_q[i]);
		end
		check_value($sformatf("%s argmax count", test), 1, arg_q.size());
		check_value($sformatf("%s argmax", test), argmax_of(expected), arg_q[0]);
		check_value($sformatf("%s argmax cycle", test), out_cyc_q[`MLP_N_OUT - 1] + 1,
		            arg_cyc_q[0]);
	endtask

	initial begin
		seed           = 8;
		cycle          = 0;
		rst_n          = 1'b0;
		i_weight_valid = 1'b0;
		i_weight_layer = '0;
		i_weight_addr  = '0;
		i_weight       = '0;
		i_data_valid   = 1'b0;
		i_data_addr    = '0;
		i_data         = '0;

		apply_reset();
		w_cur = draw_weights(1'b0);
		load_weights(w_cur);
		drive_stray_weights();
		run_pass("first_pass", draw_state(), 1'b0);
		run_pass("retained_weights", draw_state(), 1'b1);

		// fresh weights need a reset
		apply_reset();
		w_cur = draw_weights(1'b1);
		load_weights(w_cur);
		run_pass("saturation_tie", draw_state(), 1'b0);

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
+incdir+sim
design/mlp_pkg.sv
design/sync_ram.sv
design/neuron_mac.sv
design/argmax_unit.sv
design/net_controller.sv
design/mlp_top.sv
sim/tb_mlp_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_mlp_top
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_FLAGS  := --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the binary exits non-zero on $fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
